// ==== armOpb_defs.svh ====
`ifndef ARM_OPB_DEFS_SVH
`define ARM_OPB_DEFS_SVH

// Width of the data path and of every operand and result word
`define DATA_W 32

// Width of the instruction field that reaches the operand-B path
`define IR_W 24

// Four condition flags N Z C V
`define FLAG_W 4

// Barrel shift amount taken from the low instruction bits
`define SHAMT_W 5

// Class field picks where operand B comes from
`define CLASS_MSB 31
`define CLASS_LSB 29

// ALU operation field
`define OP_MSB 28
`define OP_LSB 26

`define SETF_BIT 25 // Instruction updates the stat register
`define FWDW_BIT 24 // Operand B taken from the last written result

`endif

// ==== armOpbPkg.sv ====
package armOpbPkg;

  // Operand-B source as encoded in the class field of the instruction
  typedef enum logic [2:0] {
    CLS_REG      = 3'd0, // B read port of the register file
    CLS_IMM8     = 3'd1, // Zero-extended byte immediate
    CLS_IMM12    = 3'd2,
    CLS_BRANCH   = 3'd3, // Word offset of a branch
    CLS_REGCOUNT = 3'd4, // Byte offset for a block transfer
    CLS_SHIFT    = 3'd5, // B port shifted left by the low IR bits
    CLS_HOLD     = 3'd6,
    CLS_PSR      = 3'd7  // Status word with PC and mode
  } instrClassT;

  // Bits 1..0 steer the main mux and bits 3..2 the two small ones behind it
  typedef enum logic [3:0] {
    BPORT    = 4'b0000,
    SHIFTOUT = 4'b0001,
    BRANCH   = 4'b0010,
    REGCOUNT = 4'b0011,
    HOLD     = 4'b0110,
    IMM8     = 4'b0111,
    IMM12    = 4'b1011
  } bopSelT;

  // Forward select sits in front of the source mux
  typedef enum logic [1:0] {
    FWD_EX    = 2'b00, // Write port result
    FWD_PC    = 2'b01, // PC word with stat on top
    FWD_FLAGS = 2'b10, // PC word with live ALU flags on top
    FWD_NONE  = 2'b11  // Let bopSel decide
  } fwdSelT;

  typedef enum logic [2:0] {
    ADD  = 3'd0,
    SUB  = 3'd1,
    AND  = 3'd2,
    ORR  = 3'd3,
    EOR  = 3'd4,
    MOVB = 3'd5 // Pass shifted operand B straight through
  } aluOpT;

endpackage

// ==== instrDecode.sv ====
`timescale 1ns/10ps
`include "armOpb_defs.svh"

module instrDecode import armOpbPkg::*; (
  input  logic                instrValid, // One-cycle instruction strobe
  input  logic [`DATA_W-1:0]  instr,
  output bopSelT              bopSel,
  output fwdSelT              fwdSel,
  output aluOpT               aluOp,
  output logic                setFlags,
  output logic [`SHAMT_W-1:0] shiftAmt,
  output logic                aluValid    // Marks a live slot for the execute stage
);

  instrClassT instrClass;
  logic [2:0] opField;
  logic       fwdBit;

  assign instrClass = instrClassT'(instr[`CLASS_MSB:`CLASS_LSB]);
  assign opField = instr[`OP_MSB:`OP_LSB];
  assign fwdBit = instr[`FWDW_BIT]; // Forward request overrides the class

  always_comb begin
    // Idle slot keeps operand B in place and sends a dead strobe down the pipe
    bopSel = HOLD;
    fwdSel = FWD_NONE;
    aluOp = MOVB;
    setFlags = 1'b0;
    shiftAmt = '0;
    aluValid = 1'b0;

    if (instrValid) begin
      aluValid = 1'b1;
      setFlags = instr[`SETF_BIT];

      // Codes 6 and 7 are spare and behave as a move
      case (opField)
        3'd0:    aluOp = ADD;
        3'd1:    aluOp = SUB;
        3'd2:    aluOp = AND;
        3'd3:    aluOp = ORR;
        3'd4:    aluOp = EOR;
        default: aluOp = MOVB;
      endcase

      unique case (instrClass)
        CLS_REG:      bopSel = BPORT;
        CLS_IMM8:     bopSel = IMM8;
        CLS_IMM12:    bopSel = IMM12;
        CLS_BRANCH:   bopSel = BRANCH;
        CLS_REGCOUNT: bopSel = REGCOUNT;
        CLS_SHIFT: begin
          bopSel = BPORT; // Shift happens in execute on the registered value
          shiftAmt = instr[`SHAMT_W-1:0];
        end
        CLS_HOLD:     bopSel = HOLD;
        CLS_PSR: begin
          // Whole word comes from the forward muxes so bopSel stays idle
          bopSel = HOLD;
          fwdSel = FWD_PC;
        end
      endcase

      if (fwdBit) begin
        fwdSel = FWD_EX; // Result register holds the instruction two slots back
      end
    end
  end

endmodule

// ==== bop.sv ====
`timescale 1ns/10ps
`include "armOpb_defs.svh"

module bop import armOpbPkg::*; (
  input  logic                phi1,
  input  logic                rstN,
  input  logic [`DATA_W-1:0]  wPort,      // Last written result for forwarding
  input  logic [`DATA_W-1:0]  bPort,
  input  logic [`DATA_W-1:0]  bopShifted, // Shifter output from execute
  input  logic [`FLAG_W-1:0]  stat,
  input  logic [`FLAG_W-1:0]  aluFlags,
  input  logic [1:0]          mask,
  input  logic [1:0]          mode,
  input  logic [`IR_W-1:0]    incAddress,
  input  logic [`IR_W-1:0]    ir,
  input  logic [4:0]          regCount,
  input  fwdSelT              fwdSel,
  input  bopSelT              bopSel,
  output logic [`DATA_W-1:0]  bopOut
);

  logic [`DATA_W-1:0]         muxA;   // Main source mux
  logic [`DATA_W-1:0]         muxB;   // Branch offset or held value
  logic [11:0]                muxC;   // Short immediates
  logic [`DATA_W-`FLAG_W-1:0] pcWord; // Low 28 bits of the status word
  logic [`DATA_W-1:0]         bopD;

  assign pcWord = {mask, incAddress, mode};

  always_comb begin
    // Bits 3..2 pick between the small offsets
    case (bopSel[3:2])
      2'b00:   muxC = {5'b0, regCount, 2'b0}; // Register count scaled to bytes
      2'b01:   muxC = {4'b0, ir[7:0]};
      default: muxC = ir[11:0];
    endcase

    muxB = bopSel[2] ? bopOut : {6'b0, ir, 2'b0}; // Branch offset is in words

    case (bopSel[1:0])
      2'b00:   muxA = bPort;
      2'b01:   muxA = bopShifted;
      2'b10:   muxA = muxB;
      default: muxA = {20'b0, muxC};
    endcase

    // Low bits and flag nibble have their own forward muxes
    case (fwdSel)
      FWD_EX:   bopD[`DATA_W-`FLAG_W-1:0] = wPort[`DATA_W-`FLAG_W-1:0];
      FWD_NONE: bopD[`DATA_W-`FLAG_W-1:0] = muxA[`DATA_W-`FLAG_W-1:0];
      default:  bopD[`DATA_W-`FLAG_W-1:0] = pcWord; // Same word for PC and flags
    endcase

    case (fwdSel)
      FWD_EX:    bopD[`DATA_W-1:`DATA_W-`FLAG_W] = wPort[`DATA_W-1:`DATA_W-`FLAG_W];
      FWD_PC:    bopD[`DATA_W-1:`DATA_W-`FLAG_W] = stat;
      FWD_FLAGS: bopD[`DATA_W-1:`DATA_W-`FLAG_W] = aluFlags;
      default:   bopD[`DATA_W-1:`DATA_W-`FLAG_W] = muxA[`DATA_W-1:`DATA_W-`FLAG_W];
    endcase
  end

  always_ff @(posedge phi1) begin
    if (!rstN) begin
      bopOut <= '0;
    end else begin
      bopOut <= bopD; // Idle cycles select HOLD so the value stays
    end
  end

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/10ps
`include "armOpb_defs.svh"

module aluExecute import armOpbPkg::*; (
  input  logic                phi1,
  input  logic                rstN,
  input  logic                aluValid,
  input  logic [`DATA_W-1:0]  aPort,
  input  logic [`DATA_W-1:0]  bopIn,      // Registered operand B from bop
  input  aluOpT               aluOp,
  input  logic                setFlags,
  input  logic [`SHAMT_W-1:0] shiftAmt,
  output logic [`DATA_W-1:0]  bopShifted,
  output logic [`DATA_W-1:0]  sum,
  output logic [`FLAG_W-1:0]  aluFlags,   // N Z C V from the current slot
  output logic                exValid,
  output logic                exSetFlags
);

  logic [`DATA_W-1:0]  aReg;
  aluOpT               opReg;
  logic [`SHAMT_W-1:0] shiftReg;
  logic                validReg;
  logic                setFlagsReg;
  logic                carry;
  logic                overflow;

  // Captured at the same edge as operand B so both line up in one slot
  always_ff @(posedge phi1) begin
    aReg <= aPort;
    if (!rstN) begin
      opReg <= MOVB;
      shiftReg <= '0;
      validReg <= 1'b0;
      setFlagsReg <= 1'b0;
    end else begin
      opReg <= aluOp;
      shiftReg <= shiftAmt;
      validReg <= aluValid;
      setFlagsReg <= setFlags & aluValid;
    end
  end

  assign bopShifted = bopIn << shiftReg; // Zero shift for every class but CLS_SHIFT

  always_comb begin
    carry = 1'b0;
    overflow = 1'b0;
    case (opReg)
      ADD: begin
        {carry, sum} = {1'b0, aReg} + {1'b0, bopShifted};
        // Overflow when like signs give a result of the other sign
        overflow = (aReg[`DATA_W-1] == bopShifted[`DATA_W-1]) &&
                   (sum[`DATA_W-1] != aReg[`DATA_W-1]);
      end
      SUB: begin
        // Carry set means no borrow as on ARM
        {carry, sum} = {1'b0, aReg} + {1'b0, ~bopShifted} + 1'b1;
        overflow = (aReg[`DATA_W-1] != bopShifted[`DATA_W-1]) &&
                   (sum[`DATA_W-1] != aReg[`DATA_W-1]);
      end
      AND:     sum = aReg & bopShifted;
      ORR:     sum = aReg | bopShifted;
      EOR:     sum = aReg ^ bopShifted;
      default: sum = bopShifted; // MOVB
    endcase
  end

  assign aluFlags = {sum[`DATA_W-1], (sum == '0), carry, overflow};
  assign exValid = validReg;
  assign exSetFlags = setFlagsReg;

endmodule

// ==== resultWrite.sv ====
`timescale 1ns/10ps
`include "armOpb_defs.svh"

module resultWrite (
  input  logic               phi1,
  input  logic               rstN,
  input  logic               exValid,
  input  logic               exSetFlags, // Slot asked for a stat update
  input  logic [`DATA_W-1:0] sum,
  input  logic [`FLAG_W-1:0] aluFlags,
  output logic [`DATA_W-1:0] result,     // Also the write port for forwarding
  output logic [`FLAG_W-1:0] flags,
  output logic [`FLAG_W-1:0] stat,
  output logic               resultValid
);

  // Result only moves on a live slot so forwarding sees the latest write
  always_ff @(posedge phi1) begin
    if (!rstN) begin
      result <= '0;
      flags <= '0;
    end else if (exValid) begin
      result <= sum;
      flags <= aluFlags;
    end
  end

  // Stat keeps the flags of the last instruction that set them
  always_ff @(posedge phi1) begin
    if (!rstN) begin
      stat <= '0;
    end else if (exValid && exSetFlags) begin
      stat <= aluFlags;
    end
  end

  always_ff @(posedge phi1) begin
    if (!rstN) begin
      resultValid <= 1'b0;
    end else begin
      resultValid <= exValid; // One-cycle pulse two edges after the strobe
    end
  end

endmodule

// ==== opbCore.sv ====
`timescale 1ns/10ps
`include "armOpb_defs.svh"

module opbCore import armOpbPkg::*; (
  input  logic               phi1,
  input  logic               rstN,
  input  logic               instrValid,
  input  logic [`DATA_W-1:0] instr,
  input  logic [`DATA_W-1:0] aPort,      // Register file A read port
  input  logic [`DATA_W-1:0] bPort,
  input  logic [`IR_W-1:0]   incAddress, // Next PC as a word address
  input  logic [1:0]         mode,
  input  logic [1:0]         mask,
  input  logic [4:0]         regCount,
  output logic               resultValid,
  output logic [`DATA_W-1:0] result,
  output logic [`FLAG_W-1:0] flags
);

  bopSelT              bopSel;
  fwdSelT              fwdSel;
  aluOpT               aluOp;
  logic                setFlags;
  logic [`SHAMT_W-1:0] shiftAmt;
  logic                aluValid;
  logic [`DATA_W-1:0]  bopOut;
  logic [`DATA_W-1:0]  bopShifted;
  logic [`DATA_W-1:0]  sum;
  logic [`FLAG_W-1:0]  aluFlags;
  logic [`FLAG_W-1:0]  stat;
  logic                exValid;
  logic                exSetFlags;

  instrDecode uDecode (.instrValid, .instr, .bopSel, .fwdSel, .aluOp, .setFlags,
                       .shiftAmt, .aluValid);

  // Only the low IR field reaches the operand-B path
  bop uBop (.phi1, .rstN, .wPort(result), .bPort, .bopShifted, .stat, .aluFlags,
            .mask, .mode, .incAddress, .ir(instr[`IR_W-1:0]), .regCount, .fwdSel,
            .bopSel, .bopOut);

  aluExecute uExecute (.phi1, .rstN, .aluValid, .aPort, .bopIn(bopOut), .aluOp,
                       .setFlags, .shiftAmt, .bopShifted, .sum, .aluFlags,
                       .exValid, .exSetFlags);

  resultWrite uWrite (.phi1, .rstN, .exValid, .exSetFlags, .sum, .aluFlags,
                      .result, .flags, .stat, .resultValid);

endmodule

// ==== opbCore_assert.sv ====
`timescale 1ns/10ps
`include "armOpb_defs.svh"

module opbCoreAssert (
  input logic               phi1,
  input logic               rstN,
  input logic               instrValid,
  input logic               resultValid,
  input logic [`DATA_W-1:0] result,
  input logic [`FLAG_W-1:0] flags,
  input logic [`FLAG_W-1:0] stat,
  input logic [`DATA_W-1:0] bopOut,   // Operand-B register
  input logic               exValid,
  input logic               exSetFlags
);

  int failCount = 0; // Failed properties so far

  // Every strobe comes out as exactly one result two edges later
  assert property (@(posedge phi1) disable iff (!rstN)
    resultValid == $past(instrValid, 2))
  else begin
    $error("Result strobe is not two edges after the instruction strobe");
    failCount = failCount + 1;
  end

  // First edge out of reset sees the pipeline empty and all registers cleared
  assert property (@(posedge phi1) $rose(rstN) |->
    !resultValid && !exValid && result == '0 && flags == '0 && stat == '0 && bopOut == '0)
  else begin
    $error("Pipeline holds a live value right after reset");
    failCount = failCount + 1;
  end

  assert property (@(posedge phi1) disable iff (!rstN)
    stat != $past(stat) |-> $past(exValid && exSetFlags)) // Only a set-flags write moves stat
  else begin
    $error("Stat changed without a set-flags result");
    failCount = failCount + 1;
  end

endmodule

bind opbCore opbCoreAssert uChecks (.*);

// ==== opbCore_tb.sv ====
`timescale 1ns/10ps
`include "armOpb_defs.svh"

module opbCore_tb import armOpbPkg::*; ();

  localparam int TestCycles = 400; // Reset, five groups and the drain
  localparam int MaxCycles = TestCycles + TestCycles / 2;

  logic               phi1;
  logic               rstN;
  logic               instrValid;
  logic [`DATA_W-1:0] instr;
  logic [`DATA_W-1:0] aPort;
  logic [`DATA_W-1:0] bPort;
  logic [`IR_W-1:0]   incAddress;
  logic [1:0]         mode;
  logic [1:0]         mask;
  logic [4:0]         regCount;
  logic               resultValid;
  logic [`DATA_W-1:0] result;
  logic [`FLAG_W-1:0] flags;

  // Reference state, advanced once per clock in step with the DUT
  logic [`DATA_W-1:0] mBop;
  logic [`DATA_W-1:0] mResult;   // Write port as seen by forwarding
  logic [`FLAG_W-1:0] mStat;
  logic               exLive;    // Slot between edge 1 and edge 2
  logic               exSet;
  logic [`DATA_W-1:0] exSum;
  logic [`FLAG_W-1:0] exFlags;
  logic [`DATA_W-1:0] expSum[$];
  logic [`FLAG_W-1:0] expFlags[$];
  string              expName[$];
  logic [`DATA_W-1:0] rnd;
  integer             seed;
  int                 cycles;

  opbCore u_opbCore (.phi1, .rstN, .instrValid, .instr, .aPort, .bPort, .incAddress, .mode,
                     .mask, .regCount, .resultValid, .result, .flags);

  initial begin
    phi1 = 1'b0;
    forever #4 phi1 = ~phi1;
  end

  function automatic logic [`DATA_W-1:0] randWord();
    randWord = $random(seed);
  endfunction

  // Plain ARM data processing flags N Z C V where carry on SUB means no borrow
  task automatic aluModel(input aluOpT op, input logic [`DATA_W-1:0] a,
                          input logic [`DATA_W-1:0] b, output logic [`DATA_W-1:0] res,
                          output logic [`FLAG_W-1:0] nzcv);
    logic [`DATA_W:0] wide; // Sign-extended result to catch signed overflow
    logic             c;
    logic             v;
    c = 1'b0;
    v = 1'b0;
    case (op)
      ADD: begin
        res = a + b;
        c = (res < a); // Unsigned wrap means a carry out
        wide = {a[`DATA_W-1], a} + {b[`DATA_W-1], b};
        v = (wide[`DATA_W] != wide[`DATA_W-1]);
      end
      SUB: begin
        res = a - b;
        c = (a >= b);
        wide = {a[`DATA_W-1], a} - {b[`DATA_W-1], b};
        v = (wide[`DATA_W] != wide[`DATA_W-1]);
      end
      AND:     res = a & b;
      ORR:     res = a | b;
      EOR:     res = a ^ b;
      default: res = b;
    endcase
    nzcv = {res[`DATA_W-1], res == '0, c, v};
  endtask

  // Works out operand B for the slot on the bus, then applies the coming edge
  task automatic stepModel(input string name, input logic valid);
    instrClassT          cls;
    logic [`IR_W-1:0]    ir;
    logic [`DATA_W-1:0]  newBop;
    logic [`SHAMT_W-1:0] shamt;
    logic [`DATA_W-1:0]  sumRef;
    logic [`FLAG_W-1:0]  flagsRef;
    cls = instrClassT'(instr[`CLASS_MSB:`CLASS_LSB]);
    ir = instr[`IR_W-1:0];
    newBop = mBop; // Idle slots keep operand B
    shamt = '0;
    sumRef = '0;
    flagsRef = '0;
    if (valid) begin
      case (cls)
        CLS_IMM8:     newBop = {24'b0, ir[7:0]};
        CLS_IMM12:    newBop = {20'b0, ir[11:0]};
        CLS_BRANCH:   newBop = {6'b0, ir, 2'b0};
        CLS_REGCOUNT: newBop = {25'b0, regCount, 2'b0};
        CLS_HOLD:     newBop = mBop;
        CLS_PSR:      newBop = {mStat, mask, incAddress, mode}; // Stat before this edge
        default:      newBop = bPort;
      endcase
      if (cls == CLS_SHIFT) begin
        shamt = ir[`SHAMT_W-1:0];
      end
      if (instr[`FWDW_BIT]) begin
        newBop = mResult;
      end
      aluModel(aluOpT'(instr[`OP_MSB:`OP_LSB]), aPort, newBop << shamt, sumRef, flagsRef);
      expName.push_back(name);
      expSum.push_back(sumRef);
      expFlags.push_back(flagsRef);
    end
    // Older slot writes back on the same edge that captures this one
    if (exLive) begin
      mResult = exSum;
      if (exSet) begin
        mStat = exFlags;
      end
    end
    mBop = newBop;
    exLive = valid;
    exSet = valid && instr[`SETF_BIT];
    exSum = sumRef;
    exFlags = flagsRef;
  endtask

  task automatic issue(input string name, input instrClassT cls, input aluOpT op,
                       input logic setF, input logic fwd, input logic [`IR_W-1:0] ir);
    instrValid = 1'b1;
    instr = {cls, op, setF, fwd, ir};
    stepModel(name, 1'b1);
    @(posedge phi1);
    #1;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      instrValid = 1'b0;
      stepModel("", 1'b0);
      @(posedge phi1);
      #1;
    end
  endtask

  always @(negedge phi1) begin : checkResult
    string              name;
    logic [`DATA_W-1:0] wantSum;
    logic [`FLAG_W-1:0] wantFlags;
    if (rstN && resultValid) begin
      if (expSum.size() == 0) begin
        $display("Result strobe seen with no instruction in flight");
        $display("tests failed");
        $fatal(1, "Spurious result strobe");
      end else begin
        name = expName.pop_front();
        wantSum = expSum.pop_front();
        wantFlags = expFlags.pop_front();
        assert (result == wantSum) else begin
          $display("CHECK FAILED %s result expected %h actual %h", name, wantSum, result);
          $display("tests failed");
          $fatal(1, "Result mismatch");
        end
        assert (flags == wantFlags) else begin
          $display("CHECK FAILED %s flags expected %b actual %b", name, wantFlags, flags);
          $display("tests failed");
          $fatal(1, "Flag mismatch");
        end
      end
    end
    if (u_opbCore.uChecks.failCount != 0) begin
      $display("A bound assertion on opbCore failed");
      $display("tests failed");
      $fatal(1, "Bound assertion failure");
    end
  end

  always @(posedge phi1) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Run did not finish within %0d cycles", MaxCycles);
      $display("tests failed");
      $fatal(1, "Timeout");
    end
  end

  initial begin
    seed = 27071;
    cycles = 0;
    rstN = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    aPort = '0;
    bPort = '0;
    incAddress = '0;
    mode = '0;
    mask = '0;
    regCount = '0;
    mBop = '0;
    mResult = '0;
    mStat = '0;
    exLive = 1'b0;
    exSet = 1'b0;
    exSum = '0;
    exFlags = '0;
    repeat (3) @(posedge phi1);
    #1;
    rstN = 1'b1;

    // Immediate sources through a move
    repeat (8) begin
      rnd = randWord();
      regCount = rnd[4:0];
      rnd = randWord();
      issue("imm8", CLS_IMM8, MOVB, 1'b0, 1'b0, rnd[`IR_W-1:0]);
      issue("imm12", CLS_IMM12, MOVB, 1'b0, 1'b0, rnd[`IR_W-1:0]);
      issue("branch", CLS_BRANCH, MOVB, 1'b0, 1'b0, rnd[`IR_W-1:0]);
      issue("regCount", CLS_REGCOUNT, MOVB, 1'b0, 1'b0, rnd[`IR_W-1:0]);
    end
    idle(2);

    repeat (200) begin
      aPort = randWord();
      bPort = randWord();
      rnd = randWord();
      issue("aluReg", CLS_REG, aluOpT'(rnd[31:29] % 3'd5), rnd[0], 1'b0, rnd[`IR_W-1:0]);
    end
    aPort = 32'h7fff_ffff; // Signed overflow on add
    bPort = 32'h0000_0001;
    issue("addOverflow", CLS_REG, ADD, 1'b1, 1'b0, '0);
    aPort = 32'h8000_0000;
    issue("subOverflow", CLS_REG, SUB, 1'b1, 1'b0, '0);
    bPort = aPort;
    issue("subZero", CLS_REG, SUB, 1'b1, 1'b0, '0);

    // Forward right behind two results, then after a gap
    repeat (8) begin
      aPort = randWord();
      bPort = randWord();
      issue("fwdSetup", CLS_REG, ADD, 1'b0, 1'b0, '0);
      aPort = randWord();
      bPort = randWord();
      issue("fwdSetup", CLS_REG, EOR, 1'b0, 1'b0, '0);
      aPort = randWord();
      issue("fwdEx", CLS_REG, SUB, 1'b0, 1'b1, '0);
      idle(2);
      issue("fwdGap", CLS_REG, ADD, 1'b0, 1'b1, '0);
    end
    idle(1);

    repeat (12) begin
      bPort = randWord();
      rnd = randWord();
      issue("shift", CLS_SHIFT, MOVB, 1'b0, 1'b0, rnd[`IR_W-1:0]);
      bPort = randWord(); // Hold must ignore the new B port
      issue("hold", CLS_HOLD, MOVB, 1'b0, 1'b0, '0);
      idle(1);
      issue("holdAfterIdle", CLS_HOLD, MOVB, 1'b0, 1'b0, '0);
    end

    // Status word right behind a set-flags op and again once stat has settled
    repeat (10) begin
      rnd = randWord();
      incAddress = rnd[`IR_W-1:0];
      mode = rnd[25:24];
      mask = rnd[27:26];
      aPort = randWord();
      bPort = randWord();
      issue("psrSetup", CLS_REG, SUB, 1'b1, 1'b0, '0);
      issue("psrNext", CLS_PSR, MOVB, 1'b0, 1'b0, '0);
      idle(2);
      issue("psr", CLS_PSR, MOVB, 1'b0, 1'b0, '0);
    end

    idle(3);
    while (expSum.size() != 0) begin
      @(posedge phi1);
    end
    if (u_opbCore.uChecks.failCount == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "Bound assertion failure");
    end
  end

endmodule

// ==== armOpb.f ====
+incdir+.
armOpbPkg.sv
instrDecode.sv
bop.sv
aluExecute.sv
resultWrite.sv
opbCore.sv
opbCore_assert.sv
opbCore_tb.sv

// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module opbCore_tb -f armOpb.f

obj_dir/VopbCore_tb: armOpb.f armOpb_defs.svh $(wildcard *.sv)
	verilator --binary --timing --assert --top-module opbCore_tb -f armOpb.f

# The run keeps going past an assertion error so the testbench can report it
sim: obj_dir/VopbCore_tb
	./obj_dir/VopbCore_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
